// File: verilog/nx_params.svh
// ==============================
// Widths and depths shared by the
// node message front end and its testbench
// ==============================

`ifndef NX_PARAMS_SVH
`define NX_PARAMS_SVH

// Message word
`define NX_STREAM_WIDTH    32
`define NX_ADDR_ROW_WIDTH  4 // Target row, or top of decay in a broadcast
`define NX_ADDR_COL_WIDTH  4 // Target column, or bottom of decay
`define NX_COMMAND_WIDTH   2

// Whatever is left below the command field
`define NX_PAYLOAD_WIDTH   (`NX_STREAM_WIDTH - 1 - `NX_ADDR_ROW_WIDTH \
                            - `NX_ADDR_COL_WIDTH - `NX_COMMAND_WIDTH)

// Payload contents
`define NX_INSTR_WIDTH     15 // Taken from the payload top
`define NX_IO_IDX_WIDTH    3  // 8 inputs, 8 outputs

// Buffering
`define NX_IN_DEPTH        2 // Inbound FIFO entries
`define NX_EGRESS_DEPTH    2 // Entries per egress lane

`endif // NX_PARAMS_SVH

// File: verilog/nx_msg_pkg.sv
// ==============================
// Wire message format: directions,
// commands, header and inbound record
// ==============================

`default_nettype none

`include "nx_params.svh"

package nx_msg_pkg;

    localparam int NX_NUM_DIRS = 4; // Mesh neighbours

    // Arrival and departure sides of a node
    typedef enum logic [1:0] {
        NX_DIR_NORTH = 2'd0,
        NX_DIR_EAST  = 2'd1,
        NX_DIR_SOUTH = 2'd2,
        NX_DIR_WEST  = 2'd3
    } nx_direction_t;

    typedef enum logic [`NX_COMMAND_WIDTH-1:0] {
        NX_CMD_LOAD_INSTR = 2'd0,
        NX_CMD_CFG_INPUT  = 2'd1,
        NX_CMD_CFG_OUTPUT = 2'd2,
        NX_CMD_SIG_STATE  = 2'd3
    } nx_command_t;

    typedef logic [`NX_STREAM_WIDTH-1:0] nx_word_t; // Raw message word

    // Field order from MSB down
    typedef struct packed {
        logic                          broadcast;
        logic [`NX_ADDR_ROW_WIDTH-1:0] row;     // Decay upper bits in a broadcast
        logic [`NX_ADDR_COL_WIDTH-1:0] col;     // Decay lower bits in a broadcast
        nx_command_t                   command;
        logic [`NX_PAYLOAD_WIDTH-1:0]  payload;
    } nx_msg_hdr_t;

    // Inbound FIFO entry, 34 bits
    typedef struct packed {
        nx_direction_t dir; // Side it came in on
        nx_msg_hdr_t   msg;
    } nx_inbound_t;

endpackage : nx_msg_pkg

`default_nettype wire

// File: verilog/nx_node_pkg.sv
// ==============================
// Node-side action records made
// by the message decoder
// ==============================

`default_nettype none

`include "nx_params.svh"

package nx_node_pkg;

    // I/O mapping request
    typedef struct packed {
        logic                          is_input;   // Set for configure-input
        logic [`NX_ADDR_ROW_WIDTH-1:0] remote_row; // Source or destination node
        logic [`NX_ADDR_COL_WIDTH-1:0] remote_col;
        logic [`NX_IO_IDX_WIDTH-1:0]   remote_idx; // I/O index on that node
        logic [`NX_IO_IDX_WIDTH-1:0]   local_idx;  // Slot on this node
        logic                          seq;        // Sequential input
        logic                          slot;       // Output slot select, same bit as seq
        logic                          broadcast;  // Send output as broadcast
    } nx_map_req_t;

    // Signal state update
    typedef struct packed {
        logic [`NX_ADDR_ROW_WIDTH-1:0] remote_row;
        logic [`NX_ADDR_COL_WIDTH-1:0] remote_col;
        logic [`NX_IO_IDX_WIDTH-1:0]   remote_idx; // Output index on the source
        logic                          state;
    } nx_signal_upd_t;

endpackage : nx_node_pkg

`default_nettype wire

// File: verilog/nx_stream_if.sv
// ==============================
// Directed message stream with
// source and sink modports
// ==============================

`default_nettype none

`include "nx_params.svh"

interface nx_stream_if;

    logic [`NX_STREAM_WIDTH-1:0] data;  // Message word
    logic [1:0]                  dir;   // Egress side, same coding as nx_direction_t
    logic                        valid;
    logic                        ready;

    // Data and dir held stable while valid waits for ready
    modport source (output data, output dir, output valid, input ready);
    modport sink   (input data, input dir, input valid, output ready);

endinterface : nx_stream_if

`default_nettype wire

// File: verilog/nx_fifo.sv
// ==============================
// Synchronous circular FIFO with a
// type parameter for its entries
// ==============================

`default_nettype none

module nx_fifo
    import nx_msg_pkg::*;
#(
      parameter type entry_t = nx_word_t // Entry payload
    , parameter int  DEPTH   = 2         // Number of entries
) (
      input  logic   clk_i
    , input  logic   rst_i
    // Write side
    , input  entry_t wr_data_i
    , input  logic   wr_push_i
    // Read side, head shown combinationally
    , output entry_t rd_data_o
    , input  logic   rd_pop_i
    // Status
    , output logic   empty_o
    , output logic   full_o
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

entry_t           mem_q [DEPTH];
logic [PTR_W-1:0] wr_ptr_q;
logic [PTR_W-1:0] rd_ptr_q;
logic [CNT_W-1:0] count_q;
logic             push;
logic             pop;

// Wrap at DEPTH, which need not be a power of two
function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
endfunction

assign empty_o   = (count_q == '0);
assign full_o    = (count_q == CNT_W'(DEPTH));
assign push      = wr_push_i && !full_o; // Writes into a full buffer are dropped
assign pop       = rd_pop_i && !empty_o;
assign rd_data_o = mem_q[rd_ptr_q];

always_ff @(posedge clk_i) begin : p_ptrs
    if (rst_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
    end else begin
        if (push) wr_ptr_q <= ptr_next(wr_ptr_q);
        if (pop)  rd_ptr_q <= ptr_next(rd_ptr_q);
        count_q <= count_q + CNT_W'(push) - CNT_W'(pop); // Both at once leaves it level
    end
end

always_ff @(posedge clk_i) begin : p_mem
    if (push) mem_q[wr_ptr_q] <= wr_data_i;
end

endmodule : nx_fifo

`default_nettype wire

// File: verilog/nx_msg_decoder.sv
// ==============================
// Message decoder: local actions,
// routing and forward issue
// ==============================

`default_nettype none

`include "nx_params.svh"

module nx_msg_decoder
    import nx_msg_pkg::*;
    import nx_node_pkg::*;
(
      input  logic                          clk_i
    , input  logic                          rst_i
    // Node position in the mesh
    , input  logic [`NX_ADDR_ROW_WIDTH-1:0] node_row_i
    , input  logic [`NX_ADDR_COL_WIDTH-1:0] node_col_i
    // Inbound FIFO head
    , input  nx_inbound_t                   head_i
    , input  logic                          empty_i
    , output logic                          pop_o
    // Forwarded messages, one direction per transfer
    , nx_stream_if.source                   fwd
    // Local actions, single-cycle pulses
    , output nx_map_req_t                   map_req_o
    , output logic                          map_valid_o
    , output nx_signal_upd_t                signal_upd_o
    , output logic                          signal_valid_o
    , output logic [`NX_INSTR_WIDTH-1:0]    instr_data_o
    , output logic                          instr_valid_o
);

localparam int DECAY_W   = `NX_ADDR_ROW_WIDTH + `NX_ADDR_COL_WIDTH;
// Field positions within the payload, from the top down
localparam int RROW_MSB  = `NX_PAYLOAD_WIDTH - 1;
localparam int RCOL_MSB  = RROW_MSB - `NX_ADDR_ROW_WIDTH;
localparam int RIDX_MSB  = RCOL_MSB - `NX_ADDR_COL_WIDTH;
localparam int LIDX_MSB  = RIDX_MSB - `NX_IO_IDX_WIDTH;  // Mapping only
localparam int MODE_BIT  = LIDX_MSB - `NX_IO_IDX_WIDTH;  // Seq and slot share it
localparam int BCAST_BIT = MODE_BIT - 1;
localparam int STATE_BIT = RIDX_MSB - `NX_IO_IDX_WIDTH;  // Signal update only

nx_msg_hdr_t              msg;
logic [DECAY_W-1:0]       decay;
logic                     addr_match;
logic                     is_local;
logic                     do_decode;
logic [NX_NUM_DIRS-1:0]   route_dirs;   // Directions for the head message
nx_msg_hdr_t              fwd_word;     // Head message as it leaves
nx_map_req_t              map_req_d;
nx_signal_upd_t           signal_upd_d;

logic [NX_NUM_DIRS-1:0]   send_dir_q;   // Directions still to issue
logic [NX_NUM_DIRS-1:0]   send_dir_d;
logic                     pop_q;
nx_msg_hdr_t              fwd_data_q;
nx_direction_t            fwd_dir_q;
nx_direction_t            fwd_dir_d;
logic                     fwd_valid_q;
logic                     fwd_valid_d;
logic                     map_valid_q;
logic                     signal_valid_q;
logic                     instr_valid_q;
nx_map_req_t              map_req_q;
nx_signal_upd_t           signal_upd_q;
logic [`NX_INSTR_WIDTH-1:0] instr_q;

assign msg        = head_i.msg;
assign decay      = {msg.row, msg.col}; // Broadcast reuses the address
assign addr_match = (msg.row == node_row_i) && (msg.col == node_col_i);
assign is_local   = msg.broadcast || addr_match;

// Record extraction from the head payload
assign map_req_d.is_input   = (msg.command == NX_CMD_CFG_INPUT);
assign map_req_d.remote_row = msg.payload[RROW_MSB -: `NX_ADDR_ROW_WIDTH];
assign map_req_d.remote_col = msg.payload[RCOL_MSB -: `NX_ADDR_COL_WIDTH];
assign map_req_d.remote_idx = msg.payload[RIDX_MSB -: `NX_IO_IDX_WIDTH];
assign map_req_d.local_idx  = msg.payload[LIDX_MSB -: `NX_IO_IDX_WIDTH];
assign map_req_d.seq        = msg.payload[MODE_BIT];
assign map_req_d.slot       = msg.payload[MODE_BIT];
assign map_req_d.broadcast  = msg.payload[BCAST_BIT];

assign signal_upd_d.remote_row = msg.payload[RROW_MSB -: `NX_ADDR_ROW_WIDTH];
assign signal_upd_d.remote_col = msg.payload[RCOL_MSB -: `NX_ADDR_COL_WIDTH];
assign signal_upd_d.remote_idx = msg.payload[RIDX_MSB -: `NX_IO_IDX_WIDTH];
assign signal_upd_d.state      = msg.payload[STATE_BIT];

// Where the head message goes next, empty when it stops here
always_comb begin : p_route
    route_dirs = '0;
    fwd_word   = msg;
    if (msg.broadcast) begin
        {fwd_word.row, fwd_word.col} = decay - DECAY_W'(1); // One hop of decay
        if (decay != '0) begin
            case (head_i.dir)                   // W S E N
                NX_DIR_NORTH: route_dirs = 4'b1110;
                NX_DIR_EAST:  route_dirs = 4'b1000;
                NX_DIR_SOUTH: route_dirs = 4'b1011;
                NX_DIR_WEST:  route_dirs = 4'b0010;
                default:      route_dirs = '0;
            endcase
        end
    end else if (msg.row < node_row_i) begin
        route_dirs = 4'b0001;                   // Row first
    end else if (msg.row > node_row_i) begin
        route_dirs = 4'b0100;
    end else if (msg.col < node_col_i) begin
        route_dirs = 4'b1000;                   // Then column
    end else if (msg.col > node_col_i) begin
        route_dirs = 4'b0010;
    end
end

// Outstanding set, decode gate and next stream transfer
always_comb begin : p_next
    int idx;
    send_dir_d = send_dir_q;
    fwd_dir_d  = fwd_dir_q;
    if (fwd_valid_q && fwd.ready) begin
        send_dir_d[fwd_dir_q] = 1'b0;           // That side is done
    end
    // At most one message every two cycles
    do_decode = (send_dir_d == '0) && !empty_i && !pop_q;
    if (do_decode) send_dir_d = route_dirs;
    // Lowest set bit wins, so N, E, S, W order
    for (idx = NX_NUM_DIRS - 1; idx >= 0; idx--) begin
        if ((!fwd_valid_q || fwd.ready) && send_dir_d[idx]) begin
            fwd_dir_d = nx_direction_t'(idx);
        end
    end
    fwd_valid_d = (send_dir_d != '0);
end

always_ff @(posedge clk_i) begin : p_ctrl
    if (rst_i) begin
        send_dir_q     <= '0;
        pop_q          <= 1'b0;
        fwd_dir_q      <= NX_DIR_NORTH;
        fwd_valid_q    <= 1'b0;
        map_valid_q    <= 1'b0;
        signal_valid_q <= 1'b0;
        instr_valid_q  <= 1'b0;
    end else begin
        send_dir_q     <= send_dir_d;
        pop_q          <= do_decode;            // Pop lands a cycle after decode
        fwd_dir_q      <= fwd_dir_d;
        fwd_valid_q    <= fwd_valid_d;
        map_valid_q    <= do_decode && is_local &&
                          (msg.command inside {NX_CMD_CFG_INPUT, NX_CMD_CFG_OUTPUT});
        signal_valid_q <= do_decode && is_local && (msg.command == NX_CMD_SIG_STATE);
        instr_valid_q  <= do_decode && is_local && (msg.command == NX_CMD_LOAD_INSTR);
    end
end

// Held from decode until the next one
always_ff @(posedge clk_i) begin : p_payload
    if (do_decode) begin
        fwd_data_q   <= fwd_word;
        map_req_q    <= map_req_d;
        signal_upd_q <= signal_upd_d;
        instr_q      <= msg.payload[RROW_MSB -: `NX_INSTR_WIDTH];
    end
end

assign pop_o          = pop_q;
assign fwd.data       = fwd_data_q;
assign fwd.dir        = fwd_dir_q;
assign fwd.valid      = fwd_valid_q;
assign map_req_o      = map_req_q;
assign map_valid_o    = map_valid_q;
assign signal_upd_o   = signal_upd_q;
assign signal_valid_o = signal_valid_q;
assign instr_data_o   = instr_q;
assign instr_valid_o  = instr_valid_q;

endmodule : nx_msg_decoder

`default_nettype wire

// File: verilog/nx_egress_queues.sv
// ==============================
// Egress queues: one buffered
// stream per mesh direction
// ==============================

`default_nettype none

`include "nx_params.svh"

module nx_egress_queues
    import nx_msg_pkg::*;
#(
      parameter int DEPTH = `NX_EGRESS_DEPTH // Entries per lane
) (
      input  logic                             clk_i
    , input  logic                             rst_i
    // Forwarded stream from the decoder
    , nx_stream_if.sink                        fwd
    // Lanes, indexed by nx_direction_t
    , output nx_word_t [NX_NUM_DIRS-1:0]       egress_data_o
    , output logic     [NX_NUM_DIRS-1:0]       egress_valid_o
    , input  logic     [NX_NUM_DIRS-1:0]       egress_ready_i
);

logic [NX_NUM_DIRS-1:0] push;
logic [NX_NUM_DIRS-1:0] pop;
logic [NX_NUM_DIRS-1:0] empty;
logic [NX_NUM_DIRS-1:0] full;

// Stall only on the queue this word is aimed at
assign fwd.ready = !full[fwd.dir];

for (genvar lane = 0; lane < NX_NUM_DIRS; lane++) begin : g_lane
    assign push[lane] = fwd.valid && fwd.ready && (fwd.dir == 2'(lane)); // Steer by dir
    assign pop[lane]  = egress_valid_o[lane] && egress_ready_i[lane];

    nx_fifo #(
          .entry_t (nx_word_t)
        , .DEPTH   (DEPTH)
    ) u_queue (
          .clk_i     (clk_i)
        , .rst_i     (rst_i)
        , .wr_data_i (fwd.data)
        , .wr_push_i (push[lane])
        , .rd_data_o (egress_data_o[lane])
        , .rd_pop_i  (pop[lane])
        , .empty_o   (empty[lane])
        , .full_o    (full[lane])
    );

    assign egress_valid_o[lane] = !empty[lane]; // Head is the lane word
end

endmodule : nx_egress_queues

`default_nettype wire

// File: verilog/nx_node_msg_top.sv
// ==============================
// Node message front end: inbound
// FIFO, decoder, egress queues
// ==============================

`default_nettype none

`include "nx_params.svh"

module nx_node_msg_top
    import nx_msg_pkg::*;
    import nx_node_pkg::*;
(
      input  logic                          clk_i
    , input  logic                          rst_i
    // Node position
    , input  logic [`NX_ADDR_ROW_WIDTH-1:0] node_row_i
    , input  logic [`NX_ADDR_COL_WIDTH-1:0] node_col_i
    // Ingress
    , input  nx_word_t                      msg_data_i
    , input  nx_direction_t                 msg_dir_i
    , input  logic                          msg_valid_i
    , output logic                          msg_ready_o
    // Egress lanes, by direction
    , output nx_word_t [NX_NUM_DIRS-1:0]    egress_data_o
    , output logic     [NX_NUM_DIRS-1:0]    egress_valid_o
    , input  logic     [NX_NUM_DIRS-1:0]    egress_ready_i
    // Local actions
    , output nx_map_req_t                   map_req_o
    , output logic                          map_valid_o
    , output nx_signal_upd_t                signal_upd_o
    , output logic                          signal_valid_o
    , output logic [`NX_INSTR_WIDTH-1:0]    instr_data_o
    , output logic                          instr_valid_o
);

nx_inbound_t in_entry;
nx_inbound_t in_head;
logic        in_empty;
logic        in_full;
logic        in_pop;

nx_stream_if fwd_if ();

assign in_entry    = {msg_dir_i, msg_data_i}; // Tag word with arrival side
assign msg_ready_o = ~in_full;

nx_fifo #(
      .entry_t (nx_inbound_t)
    , .DEPTH   (`NX_IN_DEPTH)
) u_in_fifo (
      .clk_i     (clk_i)
    , .rst_i     (rst_i)
    , .wr_data_i (in_entry)
    , .wr_push_i (msg_valid_i && msg_ready_o)
    , .rd_data_o (in_head)
    , .rd_pop_i  (in_pop)
    , .empty_o   (in_empty)
    , .full_o    (in_full)
);

nx_msg_decoder u_decoder (
      .clk_i          (clk_i)
    , .rst_i          (rst_i)
    , .node_row_i     (node_row_i)
    , .node_col_i     (node_col_i)
    , .head_i         (in_head)
    , .empty_i        (in_empty)
    , .pop_o          (in_pop)
    , .fwd            (fwd_if.source)
    , .map_req_o      (map_req_o)
    , .map_valid_o    (map_valid_o)
    , .signal_upd_o   (signal_upd_o)
    , .signal_valid_o (signal_valid_o)
    , .instr_data_o   (instr_data_o)
    , .instr_valid_o  (instr_valid_o)
);

nx_egress_queues #(
      .DEPTH (`NX_EGRESS_DEPTH)
) u_egress (
      .clk_i          (clk_i)
    , .rst_i          (rst_i)
    , .fwd            (fwd_if.sink)
    , .egress_data_o  (egress_data_o)
    , .egress_valid_o (egress_valid_o)
    , .egress_ready_i (egress_ready_i)
);

endmodule : nx_node_msg_top

`default_nettype wire

// File: verification/nx_node_msg_props.sv
// ==============================
// Bound protocol checks on the
// node message front end
// ==============================

`default_nettype none

module nx_node_msg_props
    import nx_msg_pkg::*;
(
      input logic                       clk_i
    , input logic                       rst_i
    , input logic                       msg_ready_i
    , input nx_word_t [NX_NUM_DIRS-1:0] egress_data_i
    , input logic [NX_NUM_DIRS-1:0]     egress_valid_i
    , input logic [NX_NUM_DIRS-1:0]     egress_ready_i
    , input logic                       map_valid_i
    , input logic                       signal_valid_i
    , input logic                       instr_valid_i
);

// Lane word held while the neighbour stalls
for (genvar lane = 0; lane < NX_NUM_DIRS; lane++) begin : g_lane
    a_egress_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        egress_valid_i[lane] && !egress_ready_i[lane] |=> $stable(egress_data_i[lane]))
        else $error("egress lane %0d data changed while stalled", lane);
end

a_action_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({map_valid_i, signal_valid_i, instr_valid_i})) // One action per cycle
    else $error("more than one action valid in a cycle");

// First cycle out of reset
a_reset_state: assert property (@(posedge clk_i)
    $fell(rst_i) |-> !map_valid_i && !signal_valid_i && !instr_valid_i
                     && (egress_valid_i == '0) && msg_ready_i)
    else $error("outputs not idle after reset");

endmodule : nx_node_msg_props

bind nx_node_msg_top nx_node_msg_props u_props (
      .clk_i          (clk_i)
    , .rst_i          (rst_i)
    , .msg_ready_i    (msg_ready_o)
    , .egress_data_i  (egress_data_o)
    , .egress_valid_i (egress_valid_o)
    , .egress_ready_i (egress_ready_i)
    , .map_valid_i    (map_valid_o)
    , .signal_valid_i (signal_valid_o)
    , .instr_valid_i  (instr_valid_o)
);

`default_nettype wire

// File: verification/tb_nx_node_msg.sv
// ==============================
// Node message front end testbench:
// clock, stimulus, reference model,
// scoreboard and reporting
// ==============================

`default_nettype none

`include "nx_params.svh"

module tb_nx_node_msg
    import nx_msg_pkg::*;
    import nx_node_pkg::*;
();

localparam int WAIT_LIMIT = 300; // Cycles per wait loop
localparam logic [`NX_ADDR_ROW_WIDTH-1:0] NODE_ROW = 4'd5;
localparam logic [`NX_ADDR_COL_WIDTH-1:0] NODE_COL = 4'd6;
localparam int KIND_NONE  = 0;
localparam int KIND_MAP   = 1;
localparam int KIND_SIG   = 2;
localparam int KIND_INSTR = 3;

logic                          clk_i = 1'b0;
logic                          rst_i;
logic [`NX_ADDR_ROW_WIDTH-1:0] node_row_i;
logic [`NX_ADDR_COL_WIDTH-1:0] node_col_i;
nx_word_t                      msg_data_i;
nx_direction_t                 msg_dir_i;
logic                          msg_valid_i;
logic                          msg_ready_o;
nx_word_t [NX_NUM_DIRS-1:0]    egress_data_o;
logic [NX_NUM_DIRS-1:0]        egress_valid_o;
logic [NX_NUM_DIRS-1:0]        egress_ready_i;
nx_map_req_t                   map_req_o;
logic                          map_valid_o;
nx_signal_upd_t                signal_upd_o;
logic                          signal_valid_o;
logic [`NX_INSTR_WIDTH-1:0]    instr_data_o;
logic                          instr_valid_o;

// Scoreboard, records zero-extended to 32 bits
logic [31:0] exp_map [$];
logic [31:0] exp_sig [$];
logic [31:0] exp_ins [$];
nx_word_t    exp_lane [NX_NUM_DIRS][$]; // Per egress lane, in order
int          error_count  = 0;
int          tests_run    = 0;
int          tests_failed = 0;
logic [31:0] rng_state    = 32'd62858;

nx_node_msg_top u_dut (.*);

always #10 clk_i = ~clk_i; // 20 unit period

function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] rand_word();
    rng_state = xorshift(rng_state);
    return rng_state;
endfunction

function automatic nx_direction_t rand_dir();
    logic [31:0] r;
    r = rand_word();
    return nx_direction_t'(r[1:0]);
endfunction

// Expected action, lanes and forwarded word for one arriving message
function automatic void ref_model(
      input  logic [3:0]        row
    , input  logic [3:0]        col
    , input  nx_direction_t     dir
    , input  nx_word_t          word
    , output int                kind
    , output logic [31:0]       record
    , output logic [3:0]        dirs
    , output nx_word_t          fwd_word
);
    nx_map_req_t    m;
    nx_signal_upd_t s;
    logic [7:0]     decay;
    decay    = word[30:23]; // Row and column in a broadcast
    kind     = KIND_NONE;
    record   = '0;
    dirs     = '0;
    fwd_word = word;
    if (word[31] || (word[30:27] == row && word[26:23] == col)) begin
        case (nx_command_t'(word[22:21]))
            NX_CMD_LOAD_INSTR: begin
                kind   = KIND_INSTR;
                record = 32'(word[20:6]); // Top 15 payload bits
            end
            NX_CMD_SIG_STATE: begin
                kind         = KIND_SIG;
                s.remote_row = word[20:17];
                s.remote_col = word[16:13];
                s.remote_idx = word[12:10];
                s.state      = word[9];
                record       = 32'(s);
            end
            default: begin
                kind         = KIND_MAP;
                m.is_input   = (word[22:21] == 2'd1);
                m.remote_row = word[20:17];
                m.remote_col = word[16:13];
                m.remote_idx = word[12:10];
                m.local_idx  = word[9:7];
                m.seq        = word[6];
                m.slot       = word[6]; // Same bit, two meanings
                m.broadcast  = word[5];
                record       = 32'(m);
            end
        endcase
    end
    if (word[31]) begin
        fwd_word[30:23] = decay - 8'd1;
        if (decay != 8'd0) begin
            case (dir)
                NX_DIR_NORTH: begin
                    dirs[NX_DIR_EAST]  = 1'b1;
                    dirs[NX_DIR_SOUTH] = 1'b1;
                    dirs[NX_DIR_WEST]  = 1'b1;
                end
                NX_DIR_EAST:  dirs[NX_DIR_WEST] = 1'b1;
                NX_DIR_SOUTH: begin
                    dirs[NX_DIR_NORTH] = 1'b1;
                    dirs[NX_DIR_EAST]  = 1'b1;
                    dirs[NX_DIR_WEST]  = 1'b1;
                end
                default:      dirs[NX_DIR_EAST] = 1'b1; // From west
            endcase
        end
    end else if (word[30:27] < row) begin
        dirs[NX_DIR_NORTH] = 1'b1;
    end else if (word[30:27] > row) begin
        dirs[NX_DIR_SOUTH] = 1'b1;
    end else if (word[26:23] < col) begin
        dirs[NX_DIR_WEST] = 1'b1;
    end else if (word[26:23] > col) begin
        dirs[NX_DIR_EAST] = 1'b1;
    end
endfunction

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
        error_count++;
        $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic report_extra(input string what);
    error_count++;
    $display("unexpected %s at %0t with nothing left to expect", what, $time);
endtask

task automatic abort_run(input string why);
    $display("timeout at %0t: %s", $time, why);
    $display("Verification failed");
    $finish;
endtask

function automatic int pending_count();
    int total;
    int lane;
    total = exp_map.size() + exp_sig.size() + exp_ins.size();
    for (lane = 0; lane < NX_NUM_DIRS; lane++) total += exp_lane[lane].size();
    return total;
endfunction

// Called on a falling edge, returns on a falling edge
task automatic send_msg(input nx_direction_t dir, input nx_word_t word);
    int          kind;
    logic [31:0] record;
    logic [3:0]  dirs;
    nx_word_t    fwd_word;
    int          lane;
    int          waited;
    ref_model(node_row_i, node_col_i, dir, word, kind, record, dirs, fwd_word);
    if (kind == KIND_MAP) exp_map.push_back(record);
    if (kind == KIND_SIG) exp_sig.push_back(record);
    if (kind == KIND_INSTR) exp_ins.push_back(record);
    for (lane = 0; lane < NX_NUM_DIRS; lane++) begin
        if (dirs[lane]) exp_lane[lane].push_back(fwd_word);
    end
    msg_data_i  = word;
    msg_dir_i   = dir;
    msg_valid_i = 1'b1;
    waited      = 0;
    while (!msg_ready_o) begin // Ready only moves on rising edges
        if (waited >= WAIT_LIMIT) abort_run("ingress never accepted a message");
        @(negedge clk_i);
        waited++;
    end
    @(negedge clk_i); // Taken at the rising edge in between
    msg_valid_i = 1'b0;
endtask

task automatic wait_drained(input string name);
    int waited;
    int settle;
    waited = 0;
    while (pending_count() != 0) begin
        if (waited >= WAIT_LIMIT) abort_run({"expected outputs missing in ", name});
        @(negedge clk_i);
        waited++;
    end
    for (settle = 0; settle < 6; settle++) @(negedge clk_i); // Catch strays
endtask

task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (error_count != errs_before) begin
        tests_failed++;
        $display("test %s: FAILED, %0d errors", name, error_count - errs_before);
    end else begin
        $display("test %s: ok", name);
    end
endtask

// Scoreboard side, samples at the rising edge
always @(posedge clk_i) begin : p_compare
    int lane;
    if (!rst_i) begin
        if (map_valid_o) begin
            if (exp_map.size() == 0) report_extra("mapping request");
            else check_value(32'(map_req_o), exp_map.pop_front(), "mapping request");
        end
        if (signal_valid_o) begin
            if (exp_sig.size() == 0) report_extra("signal update");
            else check_value(32'(signal_upd_o), exp_sig.pop_front(), "signal update");
        end
        if (instr_valid_o) begin
            if (exp_ins.size() == 0) report_extra("instruction load");
            else check_value(32'(instr_data_o), exp_ins.pop_front(), "instruction load");
        end
        for (lane = 0; lane < NX_NUM_DIRS; lane++) begin
            if (egress_valid_o[lane] && egress_ready_i[lane]) begin
                if (exp_lane[lane].size() == 0) begin
                    report_extra($sformatf("word on egress lane %0d", lane));
                end else begin
                    check_value(egress_data_o[lane], exp_lane[lane].pop_front(),
                                $sformatf("egress lane %0d", lane));
                end
            end
        end
    end
end

initial begin : p_stimulus
    int          errs_before;
    int          idx;
    int          waited;
    logic [31:0] r;
    nx_word_t    word;
    rst_i          = 1'b1;
    node_row_i     = NODE_ROW;
    node_col_i     = NODE_COL;
    msg_data_i     = '0;
    msg_dir_i      = NX_DIR_NORTH;
    msg_valid_i    = 1'b0;
    egress_ready_i = '1;
    repeat (3) @(negedge clk_i); // Three rising edges in reset
    rst_i = 1'b0;

    errs_before = error_count;
    check_value(32'({map_valid_o, signal_valid_o, instr_valid_o, egress_valid_o}), 32'd0,
                "valids after reset");
    check_value(32'(msg_ready_o), 32'd1, "msg_ready_o after reset");
    end_test("reset_state", errs_before);

    // Own address, every command
    errs_before = error_count;
    for (idx = 0; idx < 4; idx++) begin
        r    = rand_word();
        word = {1'b0, NODE_ROW, NODE_COL, 2'(idx), r[`NX_PAYLOAD_WIDTH-1:0]};
        send_msg(rand_dir(), word);
    end
    wait_drained("local_decode");
    end_test("local_decode", errs_before);

    errs_before = error_count;
    for (idx = 0; idx < 16; idx++) begin
        word     = rand_word();
        word[31] = 1'b0;
        if (word[30:23] == {NODE_ROW, NODE_COL}) word[23] = ~word[23]; // Keep it foreign
        send_msg(rand_dir(), word);
    end
    wait_drained("unicast_forward");
    end_test("unicast_forward", errs_before);

    // Each arrival side, then zero decay
    errs_before = error_count;
    for (idx = 0; idx < 8; idx++) begin
        word     = rand_word();
        word[31] = 1'b1;
        if (idx >= 4) word[30:23] = 8'd0;
        else if (idx == 0 || word[30:23] == 8'd0) word[30:23] = 8'd1; // Last hop
        send_msg(nx_direction_t'(idx[1:0]), word);
    end
    wait_drained("broadcast");
    end_test("broadcast", errs_before);

    // East lane stalled, mostly east-bound burst with some west
    errs_before = error_count;
    egress_ready_i[NX_DIR_EAST] = 1'b0;
    fork
        begin : p_burst
            for (idx = 0; idx < 10; idx++) begin
                word          = rand_word();
                word[31]      = 1'b0;
                word[30:27]   = NODE_ROW;
                word[26:23]   = (idx % 4 == 3) ? 4'd2 : 4'd9 + {2'b00, word[1:0]};
                send_msg(rand_dir(), word);
            end
        end
        begin : p_unstall
            waited = 0;
            while (msg_ready_o) begin
                if (waited >= WAIT_LIMIT) abort_run("msg_ready_o never dropped");
                @(negedge clk_i);
                waited++;
            end
            repeat (8) @(negedge clk_i); // Hold the stall a while
            egress_ready_i[NX_DIR_EAST] = 1'b1;
        end
    join
    wait_drained("back_pressure");
    end_test("back_pressure", errs_before);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             error_count);
    if (error_count == 0 && tests_failed == 0) begin
        $display("Verification passed");
    end else begin
        $display("Verification failed");
    end
    $finish;
end

endmodule : tb_nx_node_msg

`default_nettype wire

// File: list.f
+incdir+verilog
verilog/nx_msg_pkg.sv
verilog/nx_node_pkg.sv
verilog/nx_stream_if.sv
verilog/nx_fifo.sv
verilog/nx_msg_decoder.sv
verilog/nx_egress_queues.sv
verilog/nx_node_msg_top.sv
verification/nx_node_msg_props.sv
verification/tb_nx_node_msg.sv

// File: run_sim.sh
#!/bin/sh
# Builds the node message testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_nx_node_msg \
    -f list.f -o sim_nx_node_msg \
    && ./obj_dir/sim_nx_node_msg | tee /dev/stderr | grep "Verification passed" > /dev/null \
    && echo "simulation run ok" \
    || { echo "simulation run not ok"; exit 1; }
